//--- hdl/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

`default_nettype none

// UART register map
`define UART_RX_READY_ADDR 32'h8000_0000
`define UART_TX_READY_ADDR 32'h8000_0004
`define UART_TX_DATA_ADDR  32'h8000_0008
`define UART_RX_DATA_ADDR  32'h8000_000c

// Region bits within address[31:28]
// Bit 3 must be clear for either memory region
`define IM_REGION_BIT 1
`define DM_REGION_BIT 0

`default_nettype wire

`endif

//--- hdl/mipsPkg.sv
`default_nettype none

package mipsPkg;

  // Primary opcode field, instruction[31:26]
  typedef enum logic [5:0] {
    opRType = 6'd0,
    opJ     = 6'd2,
    opJal   = 6'd3,
    opBeq   = 6'd4,
    opBne   = 6'd5,
    opBlez  = 6'd6,
    opBgtz  = 6'd7,
    opAddiu = 6'd9,
    opSlti  = 6'd10,
    opSltiu = 6'd11,
    opAndi  = 6'd12,
    opOri   = 6'd13,
    opXori  = 6'd14,
    opLui   = 6'd15,
    opLb    = 6'd32,
    opLh    = 6'd33,
    opLw    = 6'd35,
    opLbu   = 6'd36,
    opLhu   = 6'd37,
    opSb    = 6'd40,
    opSh    = 6'd41,
    opSw    = 6'd43
  } opcodeT;

  // R-type function field, instruction[5:0]
  typedef enum logic [5:0] {
    fnSll  = 6'd0,
    fnSrl  = 6'd2,
    fnSra  = 6'd3,
    fnJr   = 6'd8,
    fnJalr = 6'd9,
    fnAddu = 6'd33,
    fnSubu = 6'd35,
    fnAnd  = 6'd36,
    fnOr   = 6'd37,
    fnXor  = 6'd38,
    fnNor  = 6'd39,
    fnSlt  = 6'd42,
    fnSltu = 6'd43
  } functT;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
    aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
  } aluOpT;

  typedef enum logic [1:0] {
    pcNext     = 2'b00,
    pcBranch   = 2'b01,
    pcRegister = 2'b10,
    pcJump     = 2'b11
  } pcSelT;

  // ALU operand source
  typedef enum logic [1:0] {
    selZero      = 2'b00,
    selRegister  = 2'b01,
    selForwarded = 2'b10,
    selImmediate = 2'b11
  } operandSelT;

endpackage

`default_nettype wire

//--- hdl/aluDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module aluDecoder import mipsPkg::*; (
  input  opcodeT opcode,
  input  functT  funct,
  output aluOpT  aluOp
);

  always_comb begin
    aluOp = aluAdd;
    case (opcode)
      // Register forms select by funct
      opRType: begin
        case (funct)
          fnSll:   aluOp = aluSll;
          fnSrl:   aluOp = aluSrl;
          fnSra:   aluOp = aluSra;
          fnAddu:  aluOp = aluAdd;
          fnSubu:  aluOp = aluSub;
          fnAnd:   aluOp = aluAnd;
          fnOr:    aluOp = aluOr;
          fnXor:   aluOp = aluXor;
          fnNor:   aluOp = aluNor;
          fnSlt:   aluOp = aluSlt;
          fnSltu:  aluOp = aluSltu;
          // jr and jalr just pass rs through the adder
          default: aluOp = aluAdd;
        endcase
      end

      // Immediate group
      opAddiu: aluOp = aluAdd;
      opSlti:  aluOp = aluSlt;
      opSltiu: aluOp = aluSltu;
      opAndi:  aluOp = aluAnd;
      opOri:   aluOp = aluOr;
      opXori:  aluOp = aluXor;
      opLui:   aluOp = aluLui;

      // Compare for branch outcome
      opBeq, opBne, opBlez, opBgtz: aluOp = aluSub;

      // Address generation and link
      opLb, opLh, opLw, opLbu, opLhu,
      opSb, opSh, opSw,
      opJ, opJal: aluOp = aluAdd;

      default: aluOp = aluAdd;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/controlDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module controlDecoder import mipsPkg::*; (
  input  logic        rstN,
  input  logic [31:0] instruction,
  input  logic        branch,
  input  logic [1:0]  offset,
  output pcSelT       pcSel,
  output logic [1:0]  regDst,
  output logic        regWrite,
  output logic        memRead,
  output logic        memWrite,
  output logic [3:0]  storeMask
);

  opcodeT op;
  functT  funct;
  logic   isRType;
  logic   isImm;
  logic   isLoad;
  logic   isStore;
  logic   isJumpReg;

  assign op    = opcodeT'(instruction[31:26]);
  assign funct = functT'(instruction[5:0]);

  // Instruction classes
  assign isRType   = (op == opRType);
  assign isImm     = (op >= opAddiu) && (op <= opLui);
  assign isLoad    = op inside {opLb, opLh, opLw, opLbu, opLhu};
  assign isStore   = op inside {opSb, opSh, opSw};
  assign isJumpReg = isRType && ((funct == fnJr) || (funct == fnJalr));

  always_comb begin
    // Branch taken overrides everything else
    if (branch) begin
      pcSel = pcBranch;
    end else if ((op == opJ) || (op == opJal)) begin
      pcSel = pcJump;
    end else if (isJumpReg) begin
      pcSel = pcRegister;
    end else begin
      pcSel = pcNext;
    end

    // Destination: rd, rt, ra or none
    if (isRType) begin
      regDst = 2'b01;
    end else if (isImm || isLoad) begin
      regDst = 2'b00;
    end else if (op == opJal) begin
      regDst = 2'b10;
    end else begin
      regDst = 2'b11;
    end

    regWrite = (isRType && (funct != fnJr)) || isImm || isLoad || (op == opJal);
    memRead  = isLoad;
    memWrite = isStore;

    // Byte lanes, big-endian lane order
    case (op)
      opSb:    storeMask = 4'b1000 >> offset;
      opSh:    storeMask = 4'b1100 >> {offset[1], 1'b0};
      opSw:    storeMask = 4'b1111;
      default: storeMask = 4'b0000;
    endcase

    if (!rstN) begin
      pcSel     = pcNext;
      regDst    = 2'b00;
      regWrite  = 1'b0;
      memRead   = 1'b0;
      memWrite  = 1'b0;
      storeMask = 4'b0000;
    end
  end

endmodule

`default_nettype wire

//--- hdl/forwardSelect.sv
`timescale 1ns/1ps
`default_nettype none

module forwardSelect import mipsPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic [31:0] instruction,
  output operandSelT  aluSelA,
  output operandSelT  aluSelB,
  output logic        dinSel
);

  logic [31:0] prevInstr;
  opcodeT      op;
  functT       funct;
  opcodeT      prevOp;
  logic [4:0]  rs;
  logic [4:0]  rt;
  logic [4:0]  writer;

  function automatic operandSelT fwdSel(input logic [4:0] src, input logic [4:0] wr);
    return ((wr != 5'd0) && (src == wr)) ? selForwarded : selRegister;
  endfunction

  // Cleared value is sll r0, never forwards
  always_ff @(posedge clk) begin
    if (!rstN) begin
      prevInstr <= '0;
    end else begin
      prevInstr <= instruction;
    end
  end

  assign op     = opcodeT'(instruction[31:26]);
  assign funct  = functT'(instruction[5:0]);
  assign rs     = instruction[25:21];
  assign rt     = instruction[20:16];
  assign prevOp = opcodeT'(prevInstr[31:26]);

  // Register written by the previous instruction, 0 means none
  always_comb begin
    if (prevOp == opRType) begin
      writer = prevInstr[15:11];
    end else if (((prevOp >= opAddiu) && (prevOp <= opLui))
                 || (prevOp inside {opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw})) begin
      writer = prevInstr[20:16];
    end else begin
      writer = 5'd0;
    end
  end

  always_comb begin
    aluSelA = selRegister;
    aluSelB = selRegister;
    dinSel  = 1'b0;
    if ((op == opJal) || ((op == opRType) && (funct == fnJalr))) begin
      aluSelA = selZero;
      aluSelB = selZero;
    end else if ((op == opRType) && (funct inside {fnSll, fnSrl, fnSra})) begin
      // Shift amount goes in on A
      aluSelA = selImmediate;
      aluSelB = fwdSel(rt, writer);
    end else if ((op == opRType) || ((op >= opBeq) && (op <= opBgtz))) begin
      aluSelA = fwdSel(rs, writer);
      aluSelB = fwdSel(rt, writer);
    end else if (((op >= opAddiu) && (op <= opLui))
                 || (op inside {opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw})) begin
      aluSelA = fwdSel(rs, writer);
      aluSelB = selImmediate;
      // Store data taken from the forwarded result
      dinSel  = (writer != 5'd0) && (rt == writer);
    end

    if (!rstN) begin
      aluSelA = selZero;
      aluSelB = selZero;
      dinSel  = 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/memMapDecoder.sv
`timescale 1ns/1ps
`include "mips_config.svh"
`default_nettype none

module memMapDecoder import mipsPkg::*; (
  input  logic [31:0] address,
  input  logic [1:0]  offset,
  input  logic        memRead,
  input  logic        memWrite,
  input  logic [3:0]  storeMask,
  output logic        weIm,
  output logic        weDm,
  output logic [3:0]  imByteSel,
  output logic [3:0]  dmByteSel,
  output logic        reUart,
  output logic        weUart,
  output logic [1:0]  uartSel,
  output logic [1:0]  rdSel
);

  logic [3:0]  region;
  logic [31:0] byteAddr;
  logic        isUart;
  logic        inIm;
  logic        inDm;

  assign region   = address[31:28];
  // Byte lane comes from offset, word from address
  assign byteAddr = {address[31:2], offset};

  // Memory regions need bit 3 of the top nibble clear
  assign inIm = !region[3] && region[`IM_REGION_BIT];
  assign inDm = !region[3] && region[`DM_REGION_BIT];

  assign isUart = (byteAddr == `UART_RX_READY_ADDR) || (byteAddr == `UART_TX_READY_ADDR)
               || (byteAddr == `UART_TX_DATA_ADDR) || (byteAddr == `UART_RX_DATA_ADDR);

  assign weIm      = memWrite && inIm;
  assign weDm      = memWrite && inDm;
  assign imByteSel = weIm ? storeMask : 4'b0000;
  assign dmByteSel = weDm ? storeMask : 4'b0000;

  assign weUart = memWrite && (byteAddr == `UART_TX_DATA_ADDR);
  assign reUart = memRead && (byteAddr == `UART_RX_DATA_ADDR);

  // Status register select, RX data otherwise
  always_comb begin
    if (byteAddr == `UART_RX_READY_ADDR) begin
      uartSel = 2'b01;
    end else if (byteAddr == `UART_TX_READY_ADDR) begin
      uartSel = 2'b10;
    end else begin
      uartSel = 2'b00;
    end
  end

  // Writeback source: UART, ALU or data memory
  always_comb begin
    if (memRead && isUart) begin
      rdSel = 2'b00;
    end else if (memRead && inDm) begin
      rdSel = 2'b10;
    end else begin
      rdSel = 2'b01;
    end
  end

endmodule

`default_nettype wire

//--- hdl/controlPath.sv
`timescale 1ns/1ps
`default_nettype none

module controlPath import mipsPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic [31:0] instruction,
  input  logic [31:0] address,
  input  logic [1:0]  offset,
  input  logic        branch,
  output pcSelT       pcSel,
  output logic [1:0]  regDst,
  output logic        regWrite,
  output aluOpT       aluOp,
  output operandSelT  aluSelA,
  output operandSelT  aluSelB,
  output logic        dinSel,
  output logic        weIm,
  output logic        weDm,
  output logic [3:0]  imByteSel,
  output logic [3:0]  dmByteSel,
  output logic        reUart,
  output logic        weUart,
  output logic [1:0]  uartSel,
  output logic [1:0]  rdSel
);

  // Decoder to address map
  logic       memRead;
  logic       memWrite;
  logic [3:0] storeMask;

  aluDecoder aluDecoder_inst (
    .opcode (opcodeT'(instruction[31:26])),
    .funct  (functT'(instruction[5:0])),
    .aluOp  (aluOp)
  );

  controlDecoder controlDecoder_inst (
    .rstN        (rstN),
    .instruction (instruction),
    .branch      (branch),
    .offset      (offset),
    .pcSel       (pcSel),
    .regDst      (regDst),
    .regWrite    (regWrite),
    .memRead     (memRead),
    .memWrite    (memWrite),
    .storeMask   (storeMask)
  );

  forwardSelect forwardSelect_inst (
    .clk         (clk),
    .rstN        (rstN),
    .instruction (instruction),
    .aluSelA     (aluSelA),
    .aluSelB     (aluSelB),
    .dinSel      (dinSel)
  );

  memMapDecoder memMapDecoder_inst (
    .address   (address),
    .offset    (offset),
    .memRead   (memRead),
    .memWrite  (memWrite),
    .storeMask (storeMask),
    .weIm      (weIm),
    .weDm      (weDm),
    .imByteSel (imByteSel),
    .dmByteSel (dmByteSel),
    .reUart    (reUart),
    .weUart    (weUart),
    .uartSel   (uartSel),
    .rdSel     (rdSel)
  );

endmodule

`default_nettype wire

//--- verif/controlPath_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module controlPath_asserts (
  input logic       clk,
  input logic       rstN,
  input logic       weIm,
  input logic       weDm,
  input logic [3:0] imByteSel,
  input logic [3:0] dmByteSel,
  input logic       reUart,
  input logic       weUart
);

  // Failure tally, read from the testbench
  int failCount = 0;

  // Instruction and data regions never overlap
  memExclusive: assert property (@(posedge clk) !(weIm && weDm))
    else begin
      failCount++;
      $error("weIm and weDm set in the same cycle");
    end

  uartExclusive: assert property (@(posedge clk) !(reUart && weUart))
    else begin
      failCount++;
      $error("reUart and weUart set in the same cycle");
    end

  imLanes: assert property (@(posedge clk) !weIm |-> (imByteSel == 4'b0000))
    else begin
      failCount++;
      $error("imByteSel active without weIm");
    end

  dmLanes: assert property (@(posedge clk) !weDm |-> (dmByteSel == 4'b0000))
    else begin
      failCount++;
      $error("dmByteSel active without weDm");
    end

  resetQuiet: assert property (@(posedge clk) !rstN |->
      !(weIm || weDm || reUart || weUart) && (imByteSel == 4'b0000)
      && (dmByteSel == 4'b0000))
    else begin
      failCount++;
      $error("Strobe active during reset");
    end

endmodule

bind controlPath controlPath_asserts controlPath_asserts_inst (
  .clk       (clk),
  .rstN      (rstN),
  .weIm      (weIm),
  .weDm      (weDm),
  .imByteSel (imByteSel),
  .dmByteSel (dmByteSel),
  .reUart    (reUart),
  .weUart    (weUart)
);

`default_nettype wire

//--- verif/controlPath_tb.sv
`timescale 1ns/1ps
`include "mips_config.svh"
`default_nettype none

module controlPath_tb;

  localparam int ResetCycles = 5;
  localparam int TraceLines  = 28;
  localparam int MaxCycles   = ResetCycles + TraceLines + 20;
  localparam string TracePath = "verif/controlPath_trace.txt";

  logic        clk;
  logic        rstN;
  logic [31:0] instruction;
  logic [31:0] address;
  logic [1:0]  offset;
  logic        branch;

  logic [1:0]  pcSel;
  logic [1:0]  regDst;
  logic        regWrite;
  logic [3:0]  aluOp;
  logic [1:0]  aluSelA;
  logic [1:0]  aluSelB;
  logic        dinSel;
  logic        weIm;
  logic        weDm;
  logic [3:0]  imByteSel;
  logic [3:0]  dmByteSel;
  logic        reUart;
  logic        weUart;
  logic [1:0]  uartSel;
  logic [1:0]  rdSel;

  // Current trace line, stimulus first
  logic [31:0] trInstr;
  logic [31:0] trAddr;
  logic [31:0] trOffset;
  logic [31:0] trBranch;
  logic [31:0] expPcSel;
  logic [31:0] expRegWrite;
  logic [31:0] expSelA;
  logic [31:0] expSelB;
  logic [31:0] expWeDm;
  logic [31:0] expDmByteSel;
  logic [31:0] expWeUart;
  logic [31:0] expReUart;
  logic [31:0] expUartSel;
  logic [31:0] expRdSel;

  int fd;
  int errorCount = 0;
  int checkCount = 0;
  int lineNo = 0;
  int cycles = 0;
  bit found;

  controlPath controlPath_inst (
    .clk         (clk),
    .rstN        (rstN),
    .instruction (instruction),
    .address     (address),
    .offset      (offset),
    .branch      (branch),
    .pcSel       (pcSel),
    .regDst      (regDst),
    .regWrite    (regWrite),
    .aluOp       (aluOp),
    .aluSelA     (aluSelA),
    .aluSelB     (aluSelB),
    .dinSel      (dinSel),
    .weIm        (weIm),
    .weDm        (weDm),
    .imByteSel   (imByteSel),
    .dmByteSel   (dmByteSel),
    .reUart      (reUart),
    .weUart      (weUart),
    .uartSel     (uartSel),
    .rdSel       (rdSel)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("CHECK FAILED at %0t: line %0d %s is %0h, expected %0h",
               $time, lineNo, name, actual, expected);
    end
  endtask

  // Expected ALU operation, encoded in aluOpT order add 0 through lui 11
  function automatic logic [31:0] expectedAluOp(input logic [31:0] instr);
    logic [5:0] opc;
    logic [5:0] fn;
    logic [3:0] result;
    opc    = instr[31:26];
    fn     = instr[5:0];
    result = 4'd0;
    if (opc == 6'd0) begin
      case (fn)
        6'd0:    result = 4'd8;
        6'd2:    result = 4'd9;
        6'd3:    result = 4'd10;
        6'd35:   result = 4'd1;
        6'd36:   result = 4'd2;
        6'd37:   result = 4'd3;
        6'd38:   result = 4'd4;
        6'd39:   result = 4'd5;
        6'd42:   result = 4'd6;
        6'd43:   result = 4'd7;
        default: result = 4'd0;
      endcase
    end else begin
      case (opc)
        // Branches compare by subtraction
        6'd4, 6'd5, 6'd6, 6'd7: result = 4'd1;
        6'd10:   result = 4'd6;
        6'd11:   result = 4'd7;
        6'd12:   result = 4'd2;
        6'd13:   result = 4'd3;
        6'd14:   result = 4'd4;
        6'd15:   result = 4'd11;
        default: result = 4'd0;
      endcase
    end
    return 32'(result);
  endfunction

  // Next data line of the trace, comment and blank lines skipped
  task automatic readTraceLine(output bit ok);
    string line;
    int n;
    ok = 1'b0;
    while (!ok && !$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if ((line.len() > 0) && (line.getc(0) != "#")) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    trInstr, trAddr, trOffset, trBranch, expPcSel, expRegWrite,
                    expSelA, expSelB, expWeDm, expDmByteSel, expWeUart,
                    expReUart, expUartSel, expRdSel);
        ok = (n == 14);
      end
    end
  endtask

  // Each reset cycle would raise a different group of gated outputs
  task automatic driveResetStimulus(input int step);
    case (step)
      0: begin
        // sw to the data region
        instruction <= 32'hAD28_0000;
        address     <= 32'h1000_0000;
        branch      <= 1'b0;
      end
      1: begin
        // sw to the instruction region
        instruction <= 32'hAD28_0000;
        address     <= 32'h2000_0000;
      end
      2: begin
        // lw from UART RX data
        instruction <= 32'h8D2A_0000;
        address     <= `UART_RX_DATA_ADDR;
      end
      default: begin
        // Taken branch with a store to TX data
        instruction <= 32'hAD28_0000;
        address     <= `UART_TX_DATA_ADDR;
        branch      <= 1'b1;
      end
    endcase
  endtask

  // Every gated output must sit at 0 in reset
  task automatic checkResetOutputs();
    checkValue("pcSel", 32'(pcSel), 32'd0);
    checkValue("regDst", 32'(regDst), 32'd0);
    checkValue("regWrite", 32'(regWrite), 32'd0);
    checkValue("aluSelA", 32'(aluSelA), 32'd0);
    checkValue("aluSelB", 32'(aluSelB), 32'd0);
    checkValue("dinSel", 32'(dinSel), 32'd0);
    checkValue("weIm", 32'(weIm), 32'd0);
    checkValue("weDm", 32'(weDm), 32'd0);
    checkValue("imByteSel", 32'(imByteSel), 32'd0);
    checkValue("dmByteSel", 32'(dmByteSel), 32'd0);
    checkValue("reUart", 32'(reUart), 32'd0);
    checkValue("weUart", 32'(weUart), 32'd0);
  endtask

  task automatic checkTraceOutputs();
    checkValue("pcSel", 32'(pcSel), expPcSel);
    checkValue("regWrite", 32'(regWrite), expRegWrite);
    checkValue("aluOp", 32'(aluOp), expectedAluOp(trInstr));
    checkValue("aluSelA", 32'(aluSelA), expSelA);
    checkValue("aluSelB", 32'(aluSelB), expSelB);
    checkValue("weDm", 32'(weDm), expWeDm);
    checkValue("dmByteSel", 32'(dmByteSel), expDmByteSel);
    checkValue("weUart", 32'(weUart), expWeUart);
    checkValue("reUart", 32'(reUart), expReUart);
    checkValue("uartSel", 32'(uartSel), expUartSel);
    checkValue("rdSel", 32'(rdSel), expRdSel);
  endtask

  initial begin
    // Start in reset with a taken-branch store to TX data
    rstN        = 1'b0;
    instruction = 32'hAD28_0000;
    address     = `UART_TX_DATA_ADDR;
    offset      = 2'b00;
    branch      = 1'b1;
    fd = $fopen(TracePath, "r");
    if (fd == 0) begin
      $display("Cannot open trace file %s", TracePath);
      $display("Test failures found");
      $finish;
    end else begin
      for (int step = 0; step < ResetCycles - 1; step++) begin
        @(posedge clk);
        driveResetStimulus(step);
        @(negedge clk);
        checkResetOutputs();
      end
      // rstN rises with the first trace line on the fifth edge
      readTraceLine(found);
      while (found) begin
        lineNo++;
        @(posedge clk);
        rstN        <= 1'b1;
        instruction <= trInstr;
        address     <= trAddr;
        offset      <= trOffset[1:0];
        branch      <= trBranch[0];
        @(negedge clk);
        checkTraceOutputs();
        readTraceLine(found);
      end
      $fclose(fd);
      checkValue("trace line count", lineNo, TraceLines);
      errorCount += controlPath_inst.controlPath_asserts_inst.failCount;
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
        $display("All tests passed!");
      end else begin
        $display("Test failures found");
      end
      $finish;
    end
  end

  // Run limit
  initial begin
    while (cycles < MaxCycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: simulation ran past %0d cycles", MaxCycles);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

//--- verif/controlPath_trace.txt
# instr addr offset branch | pcSel regWrite aluSelA aluSelB weDm dmByteSel weUart reUart uartSel rdSel
# All fields hex, one line per clock cycle after reset, no column separators in data lines
00000821 00000000 0 0 0 1 1 1 0 0 0 0 0 1
00411823 00000000 0 0 0 1 1 2 0 0 0 0 0 1
00650021 00000000 0 0 0 1 2 1 0 0 0 0 0 1
00003021 00000000 0 0 0 1 1 1 0 0 0 0 0 1
00063900 00000000 0 0 0 1 3 2 0 0 0 0 0 1
10e00004 00000000 0 1 1 0 2 1 0 0 0 0 0 1
08000100 00000000 0 0 3 0 1 1 0 0 0 0 0 1
0c000200 00000000 0 0 3 1 0 0 0 0 0 0 0 1
03e00008 00000000 0 0 2 0 1 1 0 0 0 0 0 1
00a0f809 00000000 0 0 2 1 0 0 0 0 0 0 0 1
27e80005 00000000 0 1 1 1 2 3 0 0 0 0 0 1
a1280000 10000000 0 0 0 0 1 3 1 8 0 0 0 1
a1280000 10000000 1 0 0 0 1 3 1 4 0 0 0 1
a1280000 10000000 2 0 0 0 1 3 1 2 0 0 0 1
a1280000 10000000 3 0 0 0 1 3 1 1 0 0 0 1
a5280000 10000000 0 0 0 0 1 3 1 c 0 0 0 1
a5280000 10000000 1 0 0 0 1 3 1 c 0 0 0 1
a5280000 10000000 2 0 0 0 1 3 1 3 0 0 0 1
a5280000 10000000 3 0 0 0 1 3 1 3 0 0 0 1
ad280000 10000000 0 0 0 0 1 3 1 f 0 0 0 1
ad280000 40000000 0 0 0 0 1 3 0 0 0 0 0 1
8d2a0000 80000000 0 0 0 1 1 3 0 0 0 0 1 0
8d2a0000 80000004 0 0 0 1 1 3 0 0 0 0 2 0
ad280000 80000008 0 0 0 0 1 3 0 0 1 0 0 1
8d2a0000 8000000c 0 0 0 1 1 3 0 0 0 1 0 0
8d4b0000 10000010 0 0 0 1 2 3 0 0 0 0 0 2
15600008 00000000 0 0 0 0 2 1 0 0 0 0 0 1
3c0d1234 00000000 0 1 1 1 1 3 0 0 0 0 0 1

//--- controlPath.f
+incdir+hdl
hdl/mipsPkg.sv
hdl/aluDecoder.sv
hdl/controlDecoder.sv
hdl/forwardSelect.sv
hdl/memMapDecoder.sv
hdl/controlPath.sv
verif/controlPath_asserts.sv
verif/controlPath_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = controlPath_tb
FILELIST = controlPath.f
SIMARGS  = +verilator+error+limit+100
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) $(SIMARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failures found" $(LOG); then \
	  echo "Simulation FAILED"; exit 1; \
	else \
	  echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
